/* Bender.yml */
package:
  name: rv_exec_slice

sources:
  - verilog/rv_pkg.sv
  - verilog/regfile.sv
  - verilog/rv_decode.sv
  - verilog/id_ex_regs.sv
  - verilog/rv_execute.sv
  - verilog/apb_issue.sv
  - verilog/rv_exec_slice.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_rv_exec_slice.sv

/* list.f */
+incdir+tests
verilog/rv_pkg.sv
verilog/regfile.sv
verilog/rv_decode.sv
verilog/id_ex_regs.sv
verilog/rv_execute.sv
verilog/apb_issue.sv
verilog/rv_exec_slice.sv
tests/tb_rv_exec_slice.sv

/* tests/rv_ref_model.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// model state where slot 0 is never written
logic [31:0] model_regs [32];
logic [31:0] model_pc;

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input bit alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[4:0];
        3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: r = (a < b) ? 32'd1 : 32'd0;
        3'd4: r = a ^ b;
        3'd5: begin
            if (alt)
                r = $signed(a) >>> b[4:0];
            else
                r = a >> b[4:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// executes one instruction on the model and returns 0 if the encoding is rejected
function automatic bit model_step(input logic [31:0] ins);
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    bit          legal;
    opc   = ins[6:0];
    f7    = ins[31:25];
    f3    = ins[14:12];
    rd    = ins[11:7];
    a     = model_regs[ins[19:15]];
    b     = model_regs[ins[24:20]];
    legal = 1'b1;
    res   = '0;
    case (opc)
        7'b0110011: begin   // register-register
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            res   = alu_ref(f3, f7[5], a, b);
        end
        7'b0010011: begin   // register-immediate
            if (f3 == 3'd1)
                legal = (f7 == 7'h00);
            else if (f3 == 3'd5)
                legal = (f7 == 7'h00) || (f7 == 7'h20);
            res = alu_ref(f3, f3 == 3'd5 && f7[5], a, {{20{ins[31]}}, ins[31:20]});
        end
        7'b0110111: res = {ins[31:12], 12'b0};
        7'b0010111: res = model_pc + {ins[31:12], 12'b0};
        7'b1101111: res = model_pc + 32'd4;
        default:    legal = 1'b0;
    endcase
    if (legal) begin
        if (rd != 5'd0)
            model_regs[rd] = res;
        if (opc == 7'b1101111)
            model_pc = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        else
            model_pc = model_pc + 32'd4;
    end
    return legal;
endfunction

`endif

/* tests/tb_rv_exec_slice.sv */
`timescale 1ns/100ps

module tb_rv_exec_slice import rv_pkg::*; ();

    localparam logic [31:0] RESET_PC = 32'h0000_1000;
    localparam int N_IMM = 24;
    localparam int N_ALU = 48;
    localparam int N_SEQ = 200;
    // reset dump, imm + x0, alu, auipc/jal, error cases, long run with final dump
    localparam int N_XFERS = 34 + 2*N_IMM + 2 + 2*N_ALU + 10 + 36 + N_SEQ + 33;
    localparam int CYCLE_LIMIT = 8*N_XFERS + 16 + 200;

    logic        clk;
    logic        rst_n;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          seed = 95373;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          test_checks = 0;
    int          test_errors = 0;
    logic [31:0] model_errcnt;

    `include "rv_ref_model.svh"

    rv_exec_slice #(.RESET_PC(RESET_PC)) rv_exec_slice_i (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    // setup at one rising edge, access at the next, sampled mid-cycle
    task automatic apb_xfer(input logic [11:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waits;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        waits = 0;
        while (pready !== 1'b1 && waits < 16) begin
            @(negedge clk);
            waits++;
        end
        if (pready !== 1'b1) begin
            errors++;
            $display("pready never went high at t=%0t, addr %03h", $time, addr);
        end
        rdata = prdata;
        err   = pslverr;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic issue(input logic [31:0] ins);
        logic [31:0] unused;
        logic        err;
        bit          legal;
        legal = model_step(ins);
        apb_xfer(ADDR_INSTR, 1'b1, ins, unused, err);
        if (!legal)
            model_errcnt++;
        check("pslverr", {31'b0, err}, {31'b0, !legal});
    endtask

    task automatic read_check(input logic [11:0] addr, input string name,
                              input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_xfer(addr, 1'b0, '0, data, err);
        check(name, data, exp);
    endtask

    function automatic logic [11:0] reg_addr(input logic [4:0] n);
        return ADDR_REG_BASE + {5'b0, n, 2'b00};
    endfunction

    task automatic compare_all();
        for (int i = 0; i < 32; i++)
            read_check(reg_addr(5'(i)), $sformatf("x%0d", i), model_regs[i]);
        read_check(ADDR_PC, "pc", model_pc);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d checks, %0d errors", tests, name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    function automatic logic [4:0] rand_reg();  // x1..x31
        return 5'(1 + {$random(seed)} % 31);
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [4:0] rd);
        return {imm, rs1, 3'd0, rd, 7'b0010011};
    endfunction

    // alt only matters where funct7 is defined (SUB for OP and SRA for both)
    function automatic logic [31:0] alu_instr(input logic [2:0] f3, input bit alt,
                                              input bit use_imm);
        logic [11:0] imm;
        logic [6:0]  f7;
        imm = 12'($random(seed));
        if (!use_imm) begin
            f7 = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            return {f7, 5'($random(seed)), 5'($random(seed)), f3, rand_reg(), 7'b0110011};
        end
        if (f3 == 3'd1 || f3 == 3'd5)
            imm = {(alt && f3 == 3'd5) ? 7'h20 : 7'h00, imm[4:0]};
        return {imm, 5'($random(seed)), f3, rand_reg(), 7'b0010011};
    endfunction

    initial begin
        logic [31:0] ins;
        logic [31:0] data;
        logic [4:0]  rd;
        logic        err;
        int          kind;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        model_pc     = RESET_PC;
        model_errcnt = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        compare_all();
        read_check(ADDR_ERRCNT, "errcnt", '0);
        end_test("reset state");

        for (int i = 0; i < N_IMM; i++) begin
            rd = rand_reg();
            if (i % 2 == 0)
                ins = enc_addi(12'($random(seed)), 5'($random(seed)), rd);
            else
                ins = enc_u(20'($random(seed)), rd, 7'b0110111);
            issue(ins);
            read_check(reg_addr(rd), $sformatf("x%0d", rd), model_regs[rd]);
        end
        issue(enc_addi(12'h7ff, 5'd1, 5'd0));
        read_check(reg_addr(5'd0), "x0", '0);   // x0 stays zero whatever is written
        end_test("addi and lui");

        for (int i = 0; i < N_ALU; i++) begin
            ins = alu_instr(3'(i), i[3], i[4]);
            issue(ins);
            rd = ins[11:7];
            read_check(reg_addr(rd), $sformatf("x%0d", rd), model_regs[rd]);
        end
        end_test("alu operations");

        for (int i = 0; i < 2; i++) begin
            rd = rand_reg();
            issue(enc_u(20'($random(seed)), rd, 7'b0010111));
            read_check(reg_addr(rd), $sformatf("x%0d", rd), model_regs[rd]);
            rd = rand_reg();
            issue(enc_jal({20'($random(seed)), 1'b0}, rd));
            read_check(reg_addr(rd), $sformatf("x%0d", rd), model_regs[rd]);
            read_check(ADDR_PC, "pc", model_pc);
        end
        end_test("auipc and jal");

        issue(32'h0000_2083);   // lw is outside the supported set
        apb_xfer(ADDR_PC, 1'b1, 32'hdead_beef, data, err);
        model_errcnt++;
        check("pslverr", {31'b0, err}, 32'd1);
        compare_all();
        read_check(ADDR_ERRCNT, "errcnt", model_errcnt);
        end_test("rejected writes");

        for (int i = 0; i < N_SEQ; i++) begin
            kind = {$random(seed)} % 8;
            rd   = rand_reg();
            case (kind)
                5: ins = enc_u(20'($random(seed)), rd, 7'b0110111);
                6: ins = enc_u(20'($random(seed)), rd, 7'b0010111);
                7: ins = enc_jal({20'($random(seed)), 1'b0}, rd);
                default: ins = alu_instr(3'($random(seed)), 1'($random(seed)),
                                         1'($random(seed)));
            endcase
            issue(ins);
        end
        compare_all();
        end_test("back-to-back sequence");
        bus_idle();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* verilog/apb_issue.sv */
`timescale 1ns/100ps

module apb_issue import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [11:0]     paddr,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [XLEN-1:0] pwdata,
    input  logic            illegal,
    input  logic [XLEN-1:0] host_rdata,
    input  logic [XLEN-1:0] pc_next,
    input  logic            ex_valid,
    output logic [XLEN-1:0] prdata,
    output logic            pready,
    output logic            pslverr,
    output logic [XLEN-1:0] instr,
    output logic [XLEN-1:0] pc,
    output logic            stall,
    output logic [4:0]      host_raddr
);

    logic            wr_access;
    logic            wr_instr;
    logic            reg_hit;
    logic [XLEN-1:0] errcnt;

    assign pready    = 1'b1;   // no wait states
    assign wr_access = psel && penable && pwrite;
    assign wr_instr  = wr_access && (paddr == ADDR_INSTR);
    assign instr     = pwdata;
    assign stall     = !(wr_instr && !illegal);
    assign pslverr   = wr_access && (!wr_instr || illegal);

    assign host_raddr = paddr[6:2];
    assign reg_hit    = (paddr[11:7] == ADDR_REG_BASE[11:7]) && (paddr[1:0] == 2'b00);

    always_comb begin
        if (reg_hit)
            prdata = host_rdata;
        else if (paddr == ADDR_PC)
            prdata = pc;
        else if (paddr == ADDR_ERRCNT)
            prdata = errcnt;
        else
            prdata = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= RESET_PC;
            errcnt <= '0;
        end else begin
            if (ex_valid)
                pc <= pc_next;
            if (pslverr)
                errcnt <= errcnt + 1'b1;
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel);

endmodule

/* verilog/id_ex_regs.sv */
`timescale 1ns/100ps

module id_ex_regs import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,

    input  logic [XLEN-1:0] pc_in,
    input  logic [XLEN-1:0] pc4_in,
    input  logic [XLEN-1:0] data1_in,
    input  logic [XLEN-1:0] data2_in,
    input  logic [2:0]      funct3_in,
    input  logic [4:0]      rd_in,
    input  rv_opcode_e      opcode_in,
    input  logic [XLEN-1:0] imm_in,
    input  alu_op_e         alu_op_in,
    input  logic            src_imm_in,
    input  logic            wr_reg_n_in,
    input  logic            valid_in,

    output logic [XLEN-1:0] pc_out,
    output logic [XLEN-1:0] pc4_out,
    output logic [XLEN-1:0] data1_out,
    output logic [XLEN-1:0] data2_out,
    output logic [2:0]      funct3_out,
    output logic [4:0]      rd_out,
    output rv_opcode_e      opcode_out,
    output logic [XLEN-1:0] imm_out,
    output alu_op_e         alu_op_out,
    output logic            src_imm_out,
    output logic            wr_reg_n_out,
    output logic            valid_out
);

    // payload only moves on an issue and a bubble leaves it stale
    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_out      <= pc_in;
            pc4_out     <= pc4_in;
            data1_out   <= data1_in;
            data2_out   <= data2_in;
            funct3_out  <= funct3_in;
            rd_out      <= rd_in;
            opcode_out  <= opcode_in;
            imm_out     <= imm_in;
            alu_op_out  <= alu_op_in;
            src_imm_out <= src_imm_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_reg_n_out <= 1'b1;
            valid_out    <= 1'b0;
        end else if (stall) begin
            wr_reg_n_out <= 1'b1;   // bubble
            valid_out    <= 1'b0;
        end else begin
            wr_reg_n_out <= wr_reg_n_in;
            valid_out    <= valid_in;
        end
    end

    // issues never come back to back since nothing forwards
    a_single_issue: assert property (@(posedge clk) disable iff (!rst_n)
        !stall |=> stall);

endmodule

/* verilog/regfile.sv */
`timescale 1ns/100ps

module regfile import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      host_raddr,
    input  logic [4:0]      waddr,
    input  logic [XLEN-1:0] wdata,
    input  logic            wr_n,
    output logic [XLEN-1:0] data1,
    output logic [XLEN-1:0] data2,
    output logic [XLEN-1:0] host_rdata
);

    logic [XLEN-1:0] regs [1:31];  // no storage behind x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (!wr_n && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    function automatic logic [XLEN-1:0] rd_port(input logic [4:0] a);
        logic [XLEN-1:0] v;
        v = (a == 5'd0) ? '0 : regs[a];
        return v;
    endfunction

    assign data1      = rd_port(rs1);
    assign data2      = rd_port(rs2);
    assign host_rdata = rd_port(host_raddr);

endmodule

/* verilog/rv_decode.sv */
`timescale 1ns/100ps

module rv_decode import rv_pkg::*; (
    input  logic [XLEN-1:0] instr,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [4:0]      rd,
    output logic [2:0]      funct3,
    output rv_opcode_e      opcode,
    output logic [XLEN-1:0] imm,
    output alu_op_e         alu_op,
    output logic            src_imm,
    output logic            wr_reg_n,
    output logic            illegal
);

    logic [6:0] funct7;
    logic       alt;      // funct7 = 0100000 selects SUB / SRA

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign opcode = rv_opcode_e'(instr[6:0]);
    assign alt    = (funct7 == 7'b0100000);

    always_comb begin
        imm      = {{20{instr[31]}}, instr[31:20]};   // I-type by default
        alu_op   = ALU_ADD;
        src_imm  = 1'b0;
        illegal  = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                src_imm = (opcode == OPC_OP_IMM);
                case (funct3)
                    3'b000:  alu_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
                // immediates carry no funct7 except for the shifts
                if (opcode == OPC_OP || funct3 == 3'b001 || funct3 == 3'b101) begin
                    if (funct7 == 7'b0100000)
                        illegal = !(funct3 == 3'b101 || (funct3 == 3'b000 && opcode == OPC_OP));
                    else if (funct7 != 7'b0000000)
                        illegal = 1'b1;
                end
            end
            OPC_LUI: begin
                imm     = {instr[31:12], 12'b0};
                alu_op  = ALU_PASS_B;
                src_imm = 1'b1;
            end
            OPC_AUIPC: imm = {instr[31:12], 12'b0};
            OPC_JAL:   imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:   illegal = 1'b1;
        endcase
    end

    assign wr_reg_n = illegal || (rd == 5'd0); // x0 writes are dropped here

endmodule

/* verilog/rv_exec_slice.sv */
`timescale 1ns/100ps

module rv_exec_slice import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [11:0]     paddr,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [XLEN-1:0] pwdata,
    output logic [XLEN-1:0] prdata,
    output logic            pready,
    output logic            pslverr
);

    logic [XLEN-1:0] instr, pc, host_rdata, data1, data2, imm, wdata, pc_next;
    logic [4:0]      rs1, rs2, rd, host_raddr, waddr;
    logic [2:0]      funct3;
    logic            stall, illegal, src_imm, wr_reg_n, wr_n, ex_valid;
    rv_opcode_e      opcode;
    alu_op_e         alu_op;

    // id/ex outputs
    logic [XLEN-1:0] x_pc, x_pc4, x_data1, x_data2, x_imm;
    logic [2:0]      x_funct3;
    logic [4:0]      x_rd;
    rv_opcode_e      x_opcode;
    alu_op_e         x_alu_op;
    logic            x_src_imm, x_wr_reg_n, x_valid;

    wire [XLEN-1:0] pc4 = pc + 32'd4;

    apb_issue #(.RESET_PC(RESET_PC)) apb_issue_i (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .illegal, .host_rdata, .pc_next, .ex_valid,
        .prdata, .pready, .pslverr, .instr, .pc, .stall, .host_raddr
    );

    rv_decode rv_decode_i (
        .instr, .rs1, .rs2, .rd, .funct3, .opcode, .imm, .alu_op,
        .src_imm, .wr_reg_n, .illegal
    );

    regfile regfile_i (
        .clk, .rst_n, .rs1, .rs2, .host_raddr, .waddr, .wdata, .wr_n,
        .data1, .data2, .host_rdata
    );

    id_ex_regs id_ex_regs_i (
        .clk, .rst_n, .stall,
        .pc_in(pc), .pc4_in(pc4), .data1_in(data1), .data2_in(data2),
        .funct3_in(funct3), .rd_in(rd), .opcode_in(opcode), .imm_in(imm),
        .alu_op_in(alu_op), .src_imm_in(src_imm), .wr_reg_n_in(wr_reg_n),
        .valid_in(1'b1),
        .pc_out(x_pc), .pc4_out(x_pc4), .data1_out(x_data1), .data2_out(x_data2),
        .funct3_out(x_funct3), .rd_out(x_rd), .opcode_out(x_opcode), .imm_out(x_imm),
        .alu_op_out(x_alu_op), .src_imm_out(x_src_imm), .wr_reg_n_out(x_wr_reg_n),
        .valid_out(x_valid)
    );

    rv_execute rv_execute_i (
        .pc(x_pc), .pc4(x_pc4), .data1(x_data1), .data2(x_data2),
        .funct3(x_funct3), .rd(x_rd), .opcode(x_opcode), .imm(x_imm),
        .alu_op(x_alu_op), .src_imm(x_src_imm), .wr_reg_n(x_wr_reg_n),
        .valid(x_valid),
        .waddr, .wdata, .wr_n, .pc_next, .ex_valid
    );

endmodule

/* verilog/rv_execute.sv */
`timescale 1ns/100ps

module rv_execute import rv_pkg::*; (
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] pc4,
    input  logic [XLEN-1:0] data1,
    input  logic [XLEN-1:0] data2,
    input  logic [2:0]      funct3,
    input  logic [4:0]      rd,
    input  rv_opcode_e      opcode,
    input  logic [XLEN-1:0] imm,
    input  alu_op_e         alu_op,
    input  logic            src_imm,
    input  logic            wr_reg_n,
    input  logic            valid,
    output logic [4:0]      waddr,
    output logic [XLEN-1:0] wdata,
    output logic            wr_n,
    output logic [XLEN-1:0] pc_next,
    output logic            ex_valid
);

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic [4:0]      shamt;
    logic            lt;

    assign op_b  = src_imm ? imm : data2;
    assign shamt = op_b[4:0];
    // one comparator for SLT and SLTU where funct3[0] picks unsigned
    assign lt    = funct3[0] ? (data1 < op_b) : ($signed(data1) < $signed(op_b));

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_out = data1 + op_b;
            ALU_SUB:    alu_out = data1 - op_b;
            ALU_SLL:    alu_out = data1 << shamt;
            ALU_SLT,
            ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, lt};
            ALU_XOR:    alu_out = data1 ^ op_b;
            ALU_SRL:    alu_out = data1 >> shamt;
            ALU_SRA:    alu_out = $unsigned($signed(data1) >>> shamt);
            ALU_OR:     alu_out = data1 | op_b;
            ALU_AND:    alu_out = data1 & op_b;
            default:    alu_out = op_b;   // pass b
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_LUI:   wdata = imm;
            OPC_AUIPC: wdata = pc + imm;
            OPC_JAL:   wdata = pc4;     // link address
            default:   wdata = alu_out;
        endcase
    end

    assign waddr    = rd;
    assign wr_n     = wr_reg_n;
    assign pc_next  = (opcode == OPC_JAL) ? pc + imm : pc4;
    assign ex_valid = valid;

endmodule

/* verilog/rv_pkg.sv */
package rv_pkg;

    parameter int XLEN = 32;

    // major opcodes in bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // host register map
    parameter logic [11:0] ADDR_INSTR    = 12'h000; // write only
    parameter logic [11:0] ADDR_PC       = 12'h004;
    parameter logic [11:0] ADDR_ERRCNT   = 12'h008;
    parameter logic [11:0] ADDR_REG_BASE = 12'h080; // xN at base + 4*N

endpackage
